//--- verilog/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  // memory map
  localparam logic [addr_w-1:0] sram_base = 32'h8000_0000;
  localparam int sram_words = 1024;
  localparam logic [addr_w-1:0] uart_base = 32'hA000_03F8;
  localparam logic [addr_w-1:0] clint_mtime_lo = 32'h0200_BFF8;
  localparam logic [addr_w-1:0] clint_mtime_hi = 32'h0200_BFFC;
  localparam logic [addr_w-1:0] clint_cmp_lo = 32'h0200_4000;
  localparam logic [addr_w-1:0] clint_cmp_hi = 32'h0200_4004;

  localparam bit stall_enable = 1'b1;  // 0 serves the selected device on every cycle
  localparam int lfsr_w = 20;
  localparam logic [lfsr_w-1:0] lfsr_seed = 20'd101;

  typedef struct packed {
    logic write;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
  } bus_req_t;

  typedef struct packed {
    logic [data_w-1:0] rdata;
    logic err;  // set for addresses outside the map
  } bus_rsp_t;

  typedef enum logic [1:0] {
    dev_none,
    dev_sram,
    dev_uart,
    dev_clint
  } dev_sel_t;

endpackage

`default_nettype wire

//--- verilog/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
  input wire clk,
  input wire rst,
  input wire f_req_valid_i,
  input wire soc_bus_pkg::bus_req_t f_req_i,
  input wire m_req_valid_i,
  input wire soc_bus_pkg::bus_req_t m_req_i,
  input wire done_i,
  input wire soc_bus_pkg::bus_rsp_t rsp_i,
  output logic f_rsp_valid_o,
  output logic m_rsp_valid_o,
  output soc_bus_pkg::bus_rsp_t rsp_o,
  output logic grant_valid_o,
  output soc_bus_pkg::bus_req_t grant_req_o
);

  logic busy_q;   // a grant is out on the shared path
  logic owner_q;  // 0 is the fetch master, 1 the load/store master
  logic prio_q;   // master that wins when both are waiting
  logic pick_m;

  assign pick_m = m_req_valid_i && (!f_req_valid_i || prio_q);
  assign grant_valid_o = busy_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      owner_q <= 1'b0;
      prio_q <= 1'b0;
      f_rsp_valid_o <= 1'b0;
      m_rsp_valid_o <= 1'b0;
    end else begin
      f_rsp_valid_o <= 1'b0;
      m_rsp_valid_o <= 1'b0;
      if (!busy_q) begin
        if (f_req_valid_i || m_req_valid_i) begin
          busy_q <= 1'b1;
          owner_q <= pick_m;
        end
      end else if (done_i) begin
        busy_q <= 1'b0;
        prio_q <= ~owner_q;  // the other master goes first next time
        f_rsp_valid_o <= ~owner_q;
        m_rsp_valid_o <= owner_q;
      end
    end
  end

  // the winner's request is captured on the cycle the grant is taken
  always_ff @(posedge clk) begin
    if (!busy_q) begin
      grant_req_o <= pick_m ? m_req_i : f_req_i;
    end
    if (busy_q && done_i) begin
      rsp_o <= rsp_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/bus_decoder.sv
`default_nettype none

module bus_decoder (
  input wire clk,
  input wire rst,
  input wire grant_valid_i,
  input wire soc_bus_pkg::bus_req_t grant_req_i,
  input wire [soc_bus_pkg::data_w-1:0] sram_rdata_i,
  input wire [soc_bus_pkg::data_w-1:0] clint_rdata_i,
  output soc_bus_pkg::bus_req_t dev_req_o,
  output logic sram_stb_o,
  output logic uart_stb_o,
  output logic clint_stb_o,
  output logic done_o,
  output soc_bus_pkg::bus_rsp_t rsp_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_stb,
    st_resp
  } state_t;

  state_t state_q;
  logic [soc_bus_pkg::lfsr_w-1:0] lfsr_q;
  logic gate_open;
  logic [soc_bus_pkg::addr_w-1:0] sram_off;
  soc_bus_pkg::dev_sel_t sel;

  // the arbiter holds the request stable until done, so decode it directly
  assign sram_off = grant_req_i.addr - soc_bus_pkg::sram_base;

  always_comb begin
    if (sram_off < soc_bus_pkg::addr_w'(soc_bus_pkg::sram_words * 4)) begin
      sel = soc_bus_pkg::dev_sram;
    end else if (grant_req_i.addr == soc_bus_pkg::uart_base) begin
      sel = soc_bus_pkg::dev_uart;
    end else if (grant_req_i.addr == soc_bus_pkg::clint_mtime_lo ||
                 grant_req_i.addr == soc_bus_pkg::clint_mtime_hi ||
                 grant_req_i.addr == soc_bus_pkg::clint_cmp_lo ||
                 grant_req_i.addr == soc_bus_pkg::clint_cmp_hi) begin
      sel = soc_bus_pkg::dev_clint;
    end else begin
      sel = soc_bus_pkg::dev_none;
    end
  end

  assign gate_open = soc_bus_pkg::stall_enable ? lfsr_q[soc_bus_pkg::lfsr_w-1] : 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr_q <= soc_bus_pkg::lfsr_seed;
      state_q <= st_idle;
    end else begin
      lfsr_q <= {lfsr_q[soc_bus_pkg::lfsr_w-2:0],
                 lfsr_q[soc_bus_pkg::lfsr_w-1] ^ lfsr_q[soc_bus_pkg::lfsr_w-2]};
      case (state_q)
        st_idle: begin
          if (grant_valid_i && gate_open) begin
            state_q <= st_stb;
          end
        end
        st_stb: state_q <= st_resp;  // device captures its data on this edge
        default: state_q <= st_idle;
      endcase
    end
  end

  assign dev_req_o = grant_req_i;
  assign sram_stb_o = (state_q == st_stb) && (sel == soc_bus_pkg::dev_sram);
  assign uart_stb_o = (state_q == st_stb) && (sel == soc_bus_pkg::dev_uart);
  assign clint_stb_o = (state_q == st_stb) && (sel == soc_bus_pkg::dev_clint);
  assign done_o = state_q == st_resp;

  always_comb begin
    rsp_o.err = 1'b0;
    case (sel)
      soc_bus_pkg::dev_sram: rsp_o.rdata = sram_rdata_i;
      soc_bus_pkg::dev_clint: rsp_o.rdata = clint_rdata_i;
      soc_bus_pkg::dev_uart: rsp_o.rdata = '0;  // console has nothing to read
      default: begin
        rsp_o.rdata = '0;
        rsp_o.err = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/uart_tx_port.sv
`default_nettype none

module uart_tx_port (
  input wire clk,
  input wire rst,
  input wire stb_i,
  input wire soc_bus_pkg::bus_req_t req_i,
  output logic tx_valid_o,
  output logic [7:0] tx_data_o
);

  logic tx_write;

  assign tx_write = stb_i && req_i.write;  // reads are answered by the decoder

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_valid_o <= 1'b0;
    end else begin
      tx_valid_o <= tx_write;
    end
  end

  // only the low byte of the data register reaches the console
  always_ff @(posedge clk) begin
    if (tx_write) begin
      tx_data_o <= req_i.wdata[7:0];
    end
  end

endmodule

`default_nettype wire

//--- verilog/clint_timer.sv
`default_nettype none

module clint_timer (
  input wire clk,
  input wire rst,
  input wire stb_i,
  input wire soc_bus_pkg::bus_req_t req_i,
  output logic [soc_bus_pkg::data_w-1:0] rdata_o,
  output logic timer_irq_o
);

  localparam int dw = soc_bus_pkg::data_w;

  logic [2*dw-1:0] mtime_q;
  logic [2*dw-1:0] mtimecmp_q;
  logic cmp_write;

  assign cmp_write = stb_i && req_i.write;

  // mtime is free running, bus writes to it are dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtimecmp_q <= '1;  // keeps the interrupt quiet out of reset
    end else if (cmp_write) begin
      for (int i = 0; i < soc_bus_pkg::strb_w; i++) begin
        if (req_i.wstrb[i]) begin
          if (req_i.addr == soc_bus_pkg::clint_cmp_lo) begin
            mtimecmp_q[8*i +: 8] <= req_i.wdata[8*i +: 8];
          end else if (req_i.addr == soc_bus_pkg::clint_cmp_hi) begin
            mtimecmp_q[dw+8*i +: 8] <= req_i.wdata[8*i +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stb_i && !req_i.write) begin
      case (req_i.addr)
        soc_bus_pkg::clint_mtime_lo: rdata_o <= mtime_q[dw-1:0];
        soc_bus_pkg::clint_mtime_hi: rdata_o <= mtime_q[2*dw-1:dw];
        soc_bus_pkg::clint_cmp_lo: rdata_o <= mtimecmp_q[dw-1:0];
        soc_bus_pkg::clint_cmp_hi: rdata_o <= mtimecmp_q[2*dw-1:dw];
        default: rdata_o <= '0;
      endcase
    end
  end

  assign timer_irq_o = mtime_q >= mtimecmp_q;

endmodule

`default_nettype wire

//--- verilog/sram_mem.sv
`default_nettype none

module sram_mem (
  input wire clk,
  input wire stb_i,
  input wire soc_bus_pkg::bus_req_t req_i,
  output logic [soc_bus_pkg::data_w-1:0] rdata_o
);

  localparam int idx_w = $clog2(soc_bus_pkg::sram_words);

  logic [soc_bus_pkg::data_w-1:0] mem [soc_bus_pkg::sram_words];
  logic [idx_w-1:0] idx;

  assign idx = req_i.addr[idx_w+1:2];  // word offset inside the window

  always_ff @(posedge clk) begin
    if (stb_i) begin
      if (req_i.write) begin
        for (int i = 0; i < soc_bus_pkg::strb_w; i++) begin
          if (req_i.wstrb[i]) begin
            mem[idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
          end
        end
      end else begin
        rdata_o <= mem[idx];  // ready on the cycle after the strobe
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/soc_bus_top.sv
`default_nettype none

module soc_bus_top (
  input wire clk,
  input wire rst,
  input wire f_req_valid_i,
  input wire soc_bus_pkg::bus_req_t f_req_i,
  input wire m_req_valid_i,
  input wire soc_bus_pkg::bus_req_t m_req_i,
  output logic f_rsp_valid_o,
  output logic m_rsp_valid_o,
  output soc_bus_pkg::bus_rsp_t rsp_o,
  output logic tx_valid_o,
  output logic [7:0] tx_data_o,
  output logic timer_irq_o
);

  logic grant_valid;
  soc_bus_pkg::bus_req_t grant_req;
  soc_bus_pkg::bus_req_t dev_req;
  soc_bus_pkg::bus_rsp_t dec_rsp;
  logic dec_done;
  logic sram_stb;
  logic uart_stb;
  logic clint_stb;
  logic [soc_bus_pkg::data_w-1:0] sram_rdata;
  logic [soc_bus_pkg::data_w-1:0] clint_rdata;

  bus_arbiter u_arbiter (
    .clk(clk),
    .rst(rst),
    .f_req_valid_i(f_req_valid_i),
    .f_req_i(f_req_i),
    .m_req_valid_i(m_req_valid_i),
    .m_req_i(m_req_i),
    .done_i(dec_done),
    .rsp_i(dec_rsp),
    .f_rsp_valid_o(f_rsp_valid_o),
    .m_rsp_valid_o(m_rsp_valid_o),
    .rsp_o(rsp_o),
    .grant_valid_o(grant_valid),
    .grant_req_o(grant_req)
  );

  bus_decoder u_decoder (
    .clk(clk),
    .rst(rst),
    .grant_valid_i(grant_valid),
    .grant_req_i(grant_req),
    .sram_rdata_i(sram_rdata),
    .clint_rdata_i(clint_rdata),
    .dev_req_o(dev_req),
    .sram_stb_o(sram_stb),
    .uart_stb_o(uart_stb),
    .clint_stb_o(clint_stb),
    .done_o(dec_done),
    .rsp_o(dec_rsp)
  );

  uart_tx_port u_uart (
    .clk(clk),
    .rst(rst),
    .stb_i(uart_stb),
    .req_i(dev_req),
    .tx_valid_o(tx_valid_o),
    .tx_data_o(tx_data_o)
  );

  clint_timer u_clint (
    .clk(clk),
    .rst(rst),
    .stb_i(clint_stb),
    .req_i(dev_req),
    .rdata_o(clint_rdata),
    .timer_irq_o(timer_irq_o)
  );

  sram_mem u_sram (
    .clk(clk),
    .stb_i(sram_stb),
    .req_i(dev_req),
    .rdata_o(sram_rdata)
  );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int half_period = 4;
  localparam int rst_cycles = 8;

  initial begin
    clk_o = 1'b0;
    forever #(half_period) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (rst_cycles) @(posedge clk_o);
    rst_o <= 1'b0;  // released on a rising edge, seen by the DUT on the next one
  end

endmodule

`default_nettype wire

//--- test/tb_soc_bus.sv
`default_nettype none

module tb_soc_bus;

  localparam int max_cases = 64;
  localparam int rsp_timeout = 200;
  localparam int irq_timeout = 100;
  localparam int rst_timeout = 50;

  logic clk;
  logic rst;
  logic f_req_valid;
  logic m_req_valid;
  soc_bus_pkg::bus_req_t f_req;
  soc_bus_pkg::bus_req_t m_req;
  logic f_rsp_valid;
  logic m_rsp_valid;
  soc_bus_pkg::bus_rsp_t rsp;
  logic tx_valid;
  logic [7:0] tx_data;
  logic timer_irq;

  int n_cases;
  int c_test [max_cases];
  logic c_is_m [max_cases];
  logic [15:0] c_op [max_cases];  // two ascii characters
  logic [31:0] c_addr [max_cases];
  logic [31:0] c_wdata [max_cases];
  logic [3:0] c_strb [max_cases];
  logic [31:0] c_exp [max_cases];
  logic [31:0] c_mask [max_cases];
  logic c_err [max_cases];

  int seed = 32'h7030_63fc;
  int errors;
  int test_errors;
  int tests_run;
  int tests_failed;
  bit aborted;
  int tx_count;
  logic [7:0] tx_last;
  logic [31:0] last_rdata;

  tb_clock_gen u_clock_gen (.clk_o(clk), .rst_o(rst));

  soc_bus_top DUT (
    .clk(clk),
    .rst(rst),
    .f_req_valid_i(f_req_valid),
    .f_req_i(f_req),
    .m_req_valid_i(m_req_valid),
    .m_req_i(m_req),
    .f_rsp_valid_o(f_rsp_valid),
    .m_rsp_valid_o(m_rsp_valid),
    .rsp_o(rsp),
    .tx_valid_o(tx_valid),
    .tx_data_o(tx_data),
    .timer_irq_o(timer_irq)
  );

  always @(negedge clk) begin
    if (!rst && tx_valid) begin
      tx_count = tx_count + 1;
      tx_last = tx_data;
    end
  end

  function automatic string test_name(input int n);
    case (n)
      1: return "sram round trip";
      2: return "uart console";
      3: return "clint time";
      4: return "timer interrupt";
      5: return "unmapped address";
      6: return "two masters";
      default: return "unnamed";
    endcase
  endfunction

  function automatic soc_bus_pkg::bus_req_t make_req(input int idx);
    soc_bus_pkg::bus_req_t r;
    r.write = (c_op[idx] == "wr") || (c_op[idx] == "tx");
    r.addr = c_addr[idx];
    r.wdata = c_wdata[idx];
    r.wstrb = c_strb[idx];
    return r;
  endfunction

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  task automatic load_cases();
    int fd;
    int n;
    int tnum;
    string line;
    logic [7:0] mch;
    logic [15:0] opc;
    logic [31:0] a, wd, ex, mk;
    logic [3:0] sb;
    logic e;
    fd = $fopen("test/bus_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open test/bus_cases.txt");
      errors++;
      aborted = 1'b1;
    end else begin
      while (!$feof(fd) && n_cases < max_cases) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 2 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%d %s %s %h %h %h %h %h %h", tnum, mch, opc, a, wd, sb, ex, mk, e);
          if (n == 9) begin
            c_test[n_cases] = tnum;
            c_is_m[n_cases] = (mch == "m");
            c_op[n_cases] = opc;
            c_addr[n_cases] = a;
            c_wdata[n_cases] = wd;
            c_strb[n_cases] = sb;
            c_exp[n_cases] = ex;
            c_mask[n_cases] = mk;
            c_err[n_cases] = e;
            n_cases++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_rsp(input int idx);
    // for a console write the expected field holds the transmitted byte
    if (c_op[idx] != "tx") begin
      assert ((rsp.rdata & c_mask[idx]) == (c_exp[idx] & c_mask[idx])) else begin
        $display("FAILED test %0d case %0d: rsp_o.rdata = %h, expected %h under mask %h",
                 c_test[idx], idx, rsp.rdata, c_exp[idx], c_mask[idx]);
        count_error();
      end
    end
    assert (rsp.err == c_err[idx]) else begin
      $display("FAILED test %0d case %0d: rsp_o.err = %h, expected %h",
               c_test[idx], idx, rsp.err, c_err[idx]);
      count_error();
    end
    if (c_op[idx] == "ri") begin
      assert (rsp.rdata > last_rdata) else begin
        $display("FAILED test %0d case %0d: rsp_o.rdata = %h, expected above %h",
                 c_test[idx], idx, rsp.rdata, last_rdata);
        count_error();
      end
    end
    if (c_op[idx] != "wr" && c_op[idx] != "tx") begin
      last_rdata = rsp.rdata;
    end
  endtask

  task automatic run_single(input int idx);
    int start_tx;
    int waited;
    bit got;
    bit is_tx;
    is_tx = (c_op[idx] == "tx");
    start_tx = tx_count;
    @(negedge clk);
    if (c_is_m[idx]) begin
      m_req = make_req(idx);
      m_req_valid = 1'b1;
    end else begin
      f_req = make_req(idx);
      f_req_valid = 1'b1;
    end
    waited = 0;
    got = 1'b0;
    while (!got && waited < rsp_timeout) begin
      @(negedge clk);
      waited++;
      got = c_is_m[idx] ? m_rsp_valid : f_rsp_valid;
    end
    f_req_valid = 1'b0;  // the pulse ends this request
    m_req_valid = 1'b0;
    if (!got) begin
      $display("test %0d case %0d: no response within %0d cycles", c_test[idx], idx, rsp_timeout);
      count_error();
      aborted = 1'b1;
    end else begin
      check_rsp(idx);
      assert (tx_count - start_tx == (is_tx ? 1 : 0)) else begin
        $display("FAILED test %0d case %0d: tx_valid_o pulses = %h, expected %h",
                 c_test[idx], idx, tx_count - start_tx, is_tx);
        count_error();
      end
      if (is_tx) begin
        assert (tx_last == c_exp[idx][7:0]) else begin
          $display("FAILED test %0d case %0d: tx_data_o = %h, expected %h",
                   c_test[idx], idx, tx_last, c_exp[idx][7:0]);
          count_error();
        end
      end
    end
  endtask

  task automatic wait_irq(input int idx);
    int waited;
    waited = 0;
    while (timer_irq !== c_exp[idx][0] && waited < irq_timeout) begin
      @(negedge clk);
      waited++;
    end
    assert (timer_irq === c_exp[idx][0]) else begin
      $display("FAILED test %0d case %0d: timer_irq_o = %h, expected %h after %0d cycles",
               c_test[idx], idx, timer_irq, c_exp[idx][0], irq_timeout);
      count_error();
    end
  endtask

  // each master works through its own request list and m starts a random number of cycles late
  task automatic run_dual(input int first, input int last);
    int fq[$];
    int mq[$];
    int fi, mi, spacing, cycles, owner, last_owner;
    bit other_waiting;
    for (int i = first; i <= last; i++) begin
      if (c_is_m[i]) mq.push_back(i);
      else fq.push_back(i);
    end
    spacing = $random(seed) & 3;
    fi = 0;
    mi = 0;
    cycles = 0;
    last_owner = -1;
    other_waiting = 1'b0;
    while ((fi < fq.size() || mi < mq.size()) && cycles < rsp_timeout * (last - first + 1)) begin
      @(negedge clk);
      cycles++;
      owner = -1;
      if (f_rsp_valid && fi < fq.size()) begin
        check_rsp(fq[fi]);
        fi++;
        owner = 0;
      end
      if (m_rsp_valid && mi < mq.size()) begin
        check_rsp(mq[mi]);
        mi++;
        owner = 1;
      end
      if (owner >= 0) begin
        assert (!(owner == last_owner && other_waiting)) else begin
          $display("test %0d: one master was served twice while the other waited", c_test[first]);
          count_error();
        end
        last_owner = owner;
      end
      f_req_valid = fi < fq.size();
      if (f_req_valid) f_req = make_req(fq[fi]);
      m_req_valid = (mi < mq.size()) && (cycles > spacing);
      if (m_req_valid) m_req = make_req(mq[mi]);
      if (owner >= 0) other_waiting = owner ? f_req_valid : m_req_valid;
    end
    f_req_valid = 1'b0;
    m_req_valid = 1'b0;
    if (fi < fq.size() || mi < mq.size()) begin
      $display("test %0d: both masters did not get all responses in time", c_test[first]);
      count_error();
      aborted = 1'b1;
    end
  endtask

  task automatic report_test(input int n);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d (%s): passed", n, test_name(n));
    end else begin
      tests_failed++;
      $display("test %0d (%s): %0d errors", n, test_name(n), test_errors);
    end
  endtask

  initial begin
    int i, j, cur_test, waited;
    f_req_valid = 1'b0;
    m_req_valid = 1'b0;
    f_req = '0;
    m_req = '0;
    n_cases = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    aborted = 1'b0;
    tx_count = 0;
    last_rdata = '0;
    load_cases();
    waited = 0;
    while (rst !== 1'b0 && waited < rst_timeout) begin
      @(negedge clk);
      waited++;
    end
    if (rst !== 1'b0) begin
      $display("reset was never released");
      errors++;
      aborted = 1'b1;
    end
    i = 0;
    cur_test = -1;
    while (i < n_cases && !aborted) begin
      if (c_test[i] != cur_test) begin
        if (cur_test >= 0) report_test(cur_test);
        cur_test = c_test[i];
        test_errors = 0;
      end
      if (c_op[i] == "du") begin
        j = i;
        while (j + 1 < n_cases && c_op[j + 1] == "du" && c_test[j + 1] == cur_test) j++;
        run_dual(i, j);
        i = j + 1;
      end else if (c_op[i] == "iq") begin
        wait_irq(i);
        i++;
      end else begin
        run_single(i);
        i++;
      end
    end
    if (cur_test >= 0) report_test(cur_test);
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !aborted && n_cases > 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
verilog/soc_bus_pkg.sv
verilog/bus_arbiter.sv
verilog/bus_decoder.sv
verilog/uart_tx_port.sv
verilog/clint_timer.sv
verilog/sram_mem.sv
verilog/soc_bus_top.sv
test/tb_clock_gen.sv
test/tb_soc_bus.sv

//--- test/bus_cases.txt
# test master op addr wdata strb exp_rdata rdata_mask exp_err, all numbers but test in hex
# ops: wr write, rd read, ri read above the previous read, tx console write, iq irq level, du both masters
1 f wr 80000000 deadbeef f 0 0 0
1 f rd 80000000 0 0 deadbeef ffffffff 0
1 m wr 80000ffc 0badf00d f 0 0 0
1 m rd 80000ffc 0 0 0badf00d ffffffff 0
1 m wr 80000010 11223344 f 0 0 0
1 m wr 80000010 aabbccdd 5 0 0 0
1 f rd 80000010 0 0 11bb33dd ffffffff 0
2 m tx a00003f8 12345641 f 41 ff 0
2 m rd a00003f8 0 0 0 ffffffff 0
3 m rd 0200bff8 0 0 0 0 0
3 m ri 0200bff8 0 0 0 0 0
3 f rd 0200bffc 0 0 0 ffffffff 0
4 f iq 0 0 0 0 0 0
4 m wr 02004000 40 f 0 0 0
4 m wr 02004004 0 f 0 0 0
4 f iq 0 0 0 1 0 0
4 m wr 02004000 ffffffff f 0 0 0
4 m wr 02004004 ffffffff f 0 0 0
4 f iq 0 0 0 0 0 0
5 f rd 10000000 0 0 0 ffffffff 1
5 m wr 40000000 cafef00d f 0 ffffffff 1
6 f wr 80000100 a5a50001 f 0 0 0
6 f wr 80000104 a5a50002 f 0 0 0
6 m wr 80000200 5a5a0001 f 0 0 0
6 m wr 80000204 5a5a0002 f 0 0 0
6 f du 80000100 0 0 a5a50001 ffffffff 0
6 f du 80000104 0 0 a5a50002 ffffffff 0
6 m du 80000200 0 0 5a5a0001 ffffffff 0
6 m du 80000204 0 0 5a5a0002 ffffffff 0
